//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import rv_pkg::*; #(
  parameter int wait_limit = 200
) (
  input logic        clk,
  input logic        rst,
  input logic        retire_valid,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd,
  input logic [31:0] retire_rd_wdata,
  input logic        trap,
  input trap_code_e  trap_code,
  input logic        awvalid,
  input logic [2:0]  awprot,
  input logic        wvalid,
  input logic        wready,
  input logic [3:0]  wstrb,
  input logic        arvalid,
  input logic [2:0]  arprot
);

  int mismatches = 0;
  int failures   = 0;
  bit timed_out  = 1'b0; // set once a wait runs out

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  // next cycle with a retire or a raised trap
  task automatic wait_event(output bit expired);
    int n;
    n = 0;
    @(posedge clk);
    while (!retire_valid && !trap && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    expired = !retire_valid && !trap;
    if (expired) begin
      $display("timeout: no retire and no trap within %0d cycles", wait_limit);
      failures++;
      timed_out = 1'b1;
    end
  endtask

  task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                               input logic [31:0] val);
    bit expired;
    wait_event(expired);
    if (expired) return;
    if (!retire_valid) begin
      $display("unexpected trap (cause %0d) while waiting for pc %h to retire", trap_code, pc);
      failures++;
    end else begin
      compare("retire_pc", retire_pc, pc);
      compare("retire_rd", retire_rd, rd);
      compare("retire_rd_wdata", retire_rd_wdata, val);
    end
  endtask

  task automatic expect_trap(input logic [1:0] code);
    bit expired;
    wait_event(expired);
    if (expired) return;
    if (retire_valid) begin
      $display("pc %h retired where a trap was due", retire_pc);
      failures++;
      return;
    end
    compare("trap_code", trap_code, code);
    repeat (20) begin // core must stay halted
      @(posedge clk);
      if (retire_valid || !trap) begin
        $display("core left the halted state after a trap");
        failures++;
      end
    end
  endtask

  task automatic print_counts();
    $display("checker: %0d value mismatches, %0d other failures", mismatches, failures);
  endtask

  // bus side rules for every beat
  always @(posedge clk) begin
    if (!rst && wvalid && wready && wstrb !== 4'hf) begin
      $display("FAIL wstrb: got %h expected f", wstrb);
      mismatches++;
    end
    if (!rst && ((awvalid && awprot !== 3'b000) || (arvalid && arprot !== 3'b000))) begin
      $display("FAIL axprot: got %h/%h expected 0", awprot, arprot);
      mismatches++;
    end
  end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

  logic        clk;
  logic        rst = 1'b1;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic        awready = 1'b0;
  logic        wready  = 1'b0;
  logic        bvalid  = 1'b0;
  logic        arready = 1'b0;
  logic        rvalid  = 1'b0;
  logic [1:0]  bresp   = 2'b00;
  logic [1:0]  rresp   = 2'b00;
  logic [31:0] rdata   = '0;
  logic [31:0] awaddress, araddress, wdata;
  logic [2:0]  awprot, arprot;
  logic [3:0]  wstrb;
  logic        trap, retire_valid;
  trap_code_e  trap_code;
  logic [31:0] retire_pc, retire_rd_wdata;
  logic [4:0]  retire_rd;

  logic [31:0] mem   [64];
  logic [31:0] image [64]; // copied into mem during reset
  integer      seed = 32'he46773dc;
  int          ar_dly = 0, r_dly = 0, aw_dly = 0, w_dly = 0, b_dly = 0;
  logic        r_busy, aw_got, w_got;
  logic [31:0] rd_addr, wr_addr, wr_data;
  logic [3:0]  wr_strb;

  // program and expected retire sequence, one row per retire or trap
  int          n_rows = 0;
  int          tab_run   [32];
  logic [31:0] tab_pc    [32];
  logic [31:0] tab_instr [32];
  bit          tab_trap  [32];
  logic [4:0]  tab_rd    [32];
  logic [31:0] tab_val   [32]; // rd value or trap cause

  rv_top #(.reset_pc(32'h0)) i_dut (.*);

  tb_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  function automatic bit in_range(input logic [31:0] addr);
    return addr[31:8] == 24'h0; // only the 64 words answer okay
  endfunction

  function automatic logic [31:0] itype(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] stype(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] btype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] jtype(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic add_row(input int run, input logic [31:0] pc, input logic [31:0] instr,
                         input bit is_trap, input logic [4:0] rd, input logic [31:0] val);
    tab_run[n_rows]   = run;
    tab_pc[n_rows]    = pc;
    tab_instr[n_rows] = instr;
    tab_trap[n_rows]  = is_trap;
    tab_rd[n_rows]    = rd;
    tab_val[n_rows]   = val;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(0, 'h00, {20'h12345, 5'd1, op_lui}, 0, 1, 'h12345000);
    add_row(0, 'h04, itype(op_imm, f3_add, 2, 0, 12'hffb), 0, 2, 'hfffffffb);
    add_row(0, 'h08, itype(op_imm, f3_add, 3, 1, 12'h678), 0, 3, 'h12345678);
    add_row(0, 'h0c, itype(op_imm, f3_and, 4, 3, 12'h0f0), 0, 4, 'h70);
    add_row(0, 'h10, itype(op_imm, f3_or, 5, 4, 12'h300), 0, 5, 'h370);
    add_row(0, 'h14, itype(op_imm, f3_xor, 6, 3, 12'hfff), 0, 6, 'hedcba987);
    add_row(0, 'h18, itype(op_imm, f3_slt, 7, 2, 12'h003), 0, 7, 1);
    add_row(0, 'h1c, rtype(f7_base, f3_add, 8, 3, 2), 0, 8, 'h12345673);
    add_row(0, 'h20, rtype(f7_sub, f3_add, 9, 4, 5), 0, 9, 'hfffffd00);
    add_row(0, 'h24, rtype(f7_base, f3_and, 10, 3, 6), 0, 10, 0);
    add_row(0, 'h28, rtype(f7_base, f3_or, 11, 4, 5), 0, 11, 'h370);
    add_row(0, 'h2c, rtype(f7_base, f3_xor, 12, 1, 3), 0, 12, 'h678);
    add_row(0, 'h30, rtype(f7_base, f3_slt, 13, 5, 2), 0, 13, 0);
    add_row(0, 'h34, itype(op_imm, f3_add, 0, 1, 12'h005), 0, 0, 0); // write to x0 dropped
    add_row(0, 'h38, rtype(f7_base, f3_add, 14, 0, 3), 0, 14, 'h12345678);
    add_row(0, 'h3c, stype(0, 3, 12'h080), 0, 0, 0);
    add_row(0, 'h40, itype(op_load, f3_word, 15, 0, 12'h080), 0, 15, 'h12345678);
    add_row(0, 'h44, btype(f3_beq, 15, 3, 13'd8), 0, 0, 0); // taken
    add_row(0, 'h4c, btype(f3_bne, 15, 3, 13'd8), 0, 0, 0); // not taken
    add_row(0, 'h50, btype(f3_bne, 1, 3, 13'd8), 0, 0, 0);  // taken
    add_row(0, 'h58, btype(f3_beq, 1, 3, 13'd8), 0, 0, 0);  // not taken
    add_row(0, 'h5c, jtype(16, 21'd12), 0, 16, 'h60);
    add_row(0, 'h68, itype(op_imm, f3_add, 17, 16, 12'h001), 0, 17, 'h61);
    add_row(0, 'h6c, 32'hffffffff, 1, 0, trap_illegal);
    add_row(1, 'h00, itype(op_imm, f3_add, 1, 0, 12'h400), 0, 1, 'h400);
    add_row(1, 'h04, itype(op_load, f3_word, 2, 1, 12'h000), 1, 0, trap_bus); // beyond memory
    add_row(2, 'h00, itype(op_imm, f3_add, 1, 0, 12'h082), 0, 1, 'h82);
    add_row(2, 'h04, itype(op_load, f3_word, 2, 1, 12'h000), 1, 0, trap_misaligned);
  endtask

  task automatic load_image(input int run);
    for (int k = 0; k < 64; k++) begin
      image[k] = 32'hbad00000 | (k << 8); // opcode 0 traps when fetched
    end
    for (int i = 0; i < n_rows; i++) begin
      if (tab_run[i] == run) image[tab_pc[i][7:2]] = tab_instr[i];
    end
  endtask

  // AXI4-Lite slave with 0 to 3 cycles of random delay per channel
  always @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      r_busy  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      for (int k = 0; k < 64; k++) mem[k] <= image[k];
    end else begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        rd_addr <= araddress;
        r_busy  <= 1'b1;
        ar_dly  <= pick_delay();
      end else if (arvalid && !r_busy) begin
        if (ar_dly == 0) arready <= 1'b1;
        else ar_dly <= ar_dly - 1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_busy <= 1'b0;
        r_dly  <= pick_delay();
      end else if (r_busy && !rvalid) begin
        if (r_dly == 0) begin
          rvalid <= 1'b1;
          rdata  <= mem[rd_addr[7:2]];
          rresp  <= in_range(rd_addr) ? resp_okay : resp_slverr;
        end else begin
          r_dly <= r_dly - 1;
        end
      end
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        wr_addr <= awaddress;
        aw_dly  <= pick_delay();
      end else if (awvalid && !aw_got) begin
        if (aw_dly == 0) awready <= 1'b1;
        else aw_dly <= aw_dly - 1;
      end
      if (wvalid && wready) begin
        wready  <= 1'b0;
        w_got   <= 1'b1;
        wr_data <= wdata;
        wr_strb <= wstrb;
        w_dly   <= pick_delay();
      end else if (wvalid && !w_got) begin
        if (w_dly == 0) wready <= 1'b1;
        else w_dly <= w_dly - 1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_dly  <= pick_delay();
      end else if (aw_got && w_got && !bvalid) begin
        if (b_dly == 0) begin
          bvalid <= 1'b1;
          bresp  <= in_range(wr_addr) ? resp_okay : resp_slverr;
          for (int b = 0; b < 4; b++) begin
            if (in_range(wr_addr) && wr_strb[b]) mem[wr_addr[7:2]][8*b +: 8] <= wr_data[8*b +: 8];
          end
        end else begin
          b_dly <= b_dly - 1;
        end
      end
    end
  end

  initial begin
    build_table();
    for (int r = 0; r < 3 && !i_checker.timed_out; r++) begin
      @(posedge clk);
      rst <= 1'b1;
      load_image(r);
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_rows && !i_checker.timed_out; i++) begin
        if (tab_run[i] == r && tab_trap[i]) i_checker.expect_trap(tab_val[i][1:0]);
        else if (tab_run[i] == r) i_checker.expect_retire(tab_pc[i], tab_rd[i], tab_val[i]);
      end
    end
    i_checker.print_counts();
    if (i_checker.mismatches + i_checker.failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- flist.f
src/rv_pkg.sv
src/rv_mem_if.sv
src/rv_axil_master.sv
src/rv_core.sv
src/rv_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- src/rv_axil_master.sv
`timescale 1ns/1ps

module rv_axil_master import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  rv_mem_if.master          mem,
  output logic              awvalid,
  input  logic              awready,
  output logic [xlen-1:0]   awaddress,
  output logic [2:0]        awprot,
  output logic              wvalid,
  input  logic              wready,
  output logic [xlen-1:0]   wdata,
  output logic [xlen/8-1:0] wstrb,
  input  logic              bvalid,
  output logic              bready,
  input  logic [1:0]        bresp,
  output logic              arvalid,
  input  logic              arready,
  output logic [xlen-1:0]   araddress,
  output logic [2:0]        arprot,
  input  logic              rvalid,
  output logic              rready,
  input  logic [xlen-1:0]   rdata,
  input  logic [1:0]        rresp
);

  typedef enum logic [2:0] {s_idle, s_rd_addr, s_rd_data, s_wr_req, s_wr_resp} bus_state_e;

  bus_state_e state;
  logic       aw_acc; // write address taken now or earlier
  logic       w_acc;  // write data taken now or earlier

  // request fields are held by the core for the whole transaction
  assign awaddress = mem.addr;
  assign araddress = mem.addr;
  assign wdata     = mem.wdata;
  assign wstrb     = mem.wstrb;
  assign awprot    = 3'b000;
  assign arprot    = 3'b000;

  assign aw_acc = !awvalid || awready;
  assign w_acc  = !wvalid || wready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= s_idle;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      mem.done <= 1'b0;
      mem.err  <= 1'b0;
    end else begin
      mem.done <= 1'b0;
      case (state)
        s_idle: begin
          if (mem.req && mem.we) begin
            awvalid <= 1'b1; // address and data raised together
            wvalid  <= 1'b1;
            state   <= s_wr_req;
          end else if (mem.req) begin
            arvalid <= 1'b1;
            state   <= s_rd_addr;
          end
        end
        s_rd_addr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= s_rd_data;
          end
        end
        s_rd_data: begin
          if (rvalid) begin
            rready    <= 1'b0;
            mem.rdata <= rdata;
            mem.err   <= rresp != resp_okay;
            mem.done  <= 1'b1;
            state     <= s_idle;
          end
        end
        s_wr_req: begin
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (aw_acc && w_acc) begin
            bready <= 1'b1;
            state  <= s_wr_resp;
          end
        end
        s_wr_resp: begin
          if (bvalid) begin
            bready   <= 1'b0;
            mem.err  <= bresp != resp_okay;
            mem.done <= 1'b1;
            state    <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid);

  // core keeps one request in flight
  a_no_overlap: assert property (@(posedge clk) disable iff (rst) mem.req |-> state == s_idle);

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  rv_mem_if.core          mem,
  output logic            retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [4:0]      retire_rd,
  output logic [xlen-1:0] retire_rd_wdata,
  output logic            trap,
  output trap_code_e      trap_code
);

  core_state_e     state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] ir;
  logic            pend;         // fetch request outstanding
  logic [xlen-1:0] regs [1:31];

  opcode_e         opcode;
  logic [4:0]      rd, rs1, rs2;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [xlen-1:0] rs1_val, rs2_val, alu_b, alu_res, wb_val;
  logic [xlen-1:0] pc_plus4, next_pc, ls_addr;
  alu_op_e         alu_op;
  logic            f3_ok, illegal, misaligned, is_mem, taken, writes_rd;
  logic            retire_now, rf_sel, rf_we;
  logic [xlen-1:0] rf_wd;

  assign opcode = opcode_e'(ir[6:0]);
  assign rd     = ir[11:7];
  assign f3     = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign f7     = ir[31:25];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};

  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 hardwired
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_comb begin
    alu_op = alu_add;
    f3_ok  = 1'b1;
    case (f3)
      f3_add:  alu_op = (opcode == op_reg && f7 == f7_sub) ? alu_sub : alu_add;
      f3_slt:  alu_op = alu_slt;
      f3_xor:  alu_op = alu_xor;
      f3_or:   alu_op = alu_or;
      f3_and:  alu_op = alu_and;
      default: f3_ok = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_lui, op_jal:    illegal = 1'b0;
      op_imm:            illegal = !f3_ok;
      op_reg:            illegal = !f3_ok || !(f7 == f7_base || (f7 == f7_sub && f3 == f3_add));
      op_load, op_store: illegal = f3 != f3_word;
      op_branch:         illegal = f3 != f3_beq && f3 != f3_bne;
      default:           illegal = 1'b1;
    endcase
  end

  assign alu_b = (opcode == op_reg) ? rs2_val : imm_i;

  always_comb begin
    case (alu_op)
      alu_sub: alu_res = rs1_val - alu_b;
      alu_and: alu_res = rs1_val & alu_b;
      alu_or:  alu_res = rs1_val | alu_b;
      alu_xor: alu_res = rs1_val ^ alu_b;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
      default: alu_res = rs1_val + alu_b;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;
  assign taken    = (f3 == f3_beq) ? (rs1_val == rs2_val) : (rs1_val != rs2_val);

  always_comb begin
    next_pc = pc_plus4;
    if (opcode == op_jal) begin
      next_pc = pc + imm_j;
    end else if (opcode == op_branch && taken) begin
      next_pc = pc + imm_b;
    end
  end

  assign is_mem     = opcode == op_load || opcode == op_store;
  assign ls_addr    = rs1_val + ((opcode == op_store) ? imm_s : imm_i);
  assign misaligned = is_mem ? (ls_addr[1:0] != 2'b00) : (next_pc[1:0] != 2'b00);
  assign writes_rd  = opcode == op_lui || opcode == op_imm || opcode == op_reg
                      || opcode == op_jal;
  assign wb_val     = (opcode == op_lui) ? imm_u : (opcode == op_jal) ? pc_plus4 : alu_res;

  // completion of an instruction, either in exec or after its data access
  assign retire_now = (state == st_exec && !illegal && !misaligned && !is_mem)
                      || (state == st_mem && mem.done && !mem.err);
  assign rf_sel = (state == st_mem) ? !mem.we : writes_rd;
  assign rf_wd  = (state == st_mem) ? mem.rdata : wb_val;
  assign rf_we  = retire_now && rf_sel && rd != 5'd0;

  always_ff @(posedge clk) begin
    if (rf_we) regs[rd] <= rf_wd;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_fetch;
      pc        <= reset_pc;
      pend      <= 1'b0;
      mem.req   <= 1'b0;
      trap      <= 1'b0;
      trap_code <= trap_illegal;
    end else begin
      mem.req <= 1'b0;
      if (retire_now) begin
        pc    <= next_pc; // equals pc+4 for loads and stores
        state <= st_fetch;
      end
      case (state)
        st_fetch: begin
          if (!pend) begin
            mem.req  <= 1'b1;
            mem.we   <= 1'b0;
            mem.addr <= pc;
            pend     <= 1'b1;
          end else if (mem.done) begin
            pend <= 1'b0;
            if (mem.err) begin
              trap      <= 1'b1;
              trap_code <= trap_bus;
              state     <= st_halt;
            end else begin
              ir    <= mem.rdata;
              state <= st_exec;
            end
          end
        end
        st_exec: begin
          if (illegal || misaligned) begin
            trap      <= 1'b1;
            trap_code <= illegal ? trap_illegal : trap_misaligned;
            state     <= st_halt;
          end else if (is_mem) begin
            mem.req   <= 1'b1;
            mem.we    <= opcode == op_store;
            mem.addr  <= ls_addr;
            mem.wdata <= rs2_val;
            mem.wstrb <= (opcode == op_store) ? '1 : '0; // word stores only
            state     <= st_mem;
          end
        end
        st_mem: begin
          if (mem.done && mem.err) begin
            trap      <= 1'b1;
            trap_code <= trap_bus;
            state     <= st_halt;
          end
        end
        default: state <= st_halt; // halted until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire_now;
    end
    if (retire_now) begin
      retire_pc       <= pc;
      retire_rd       <= rf_sel ? rd : 5'd0;
      retire_rd_wdata <= rf_we ? rf_wd : '0;
    end
  end

  a_no_retire_halt: assert property (@(posedge clk) disable iff (rst)
    !(retire_valid && state == st_halt));

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- src/rv_mem_if.sv
`timescale 1ns/1ps

interface rv_mem_if import rv_pkg::*; ();

  logic                req;   // one-cycle request strobe
  logic                we;    // write when high
  logic [xlen-1:0]     addr;
  logic [xlen-1:0]     wdata;
  logic [xlen/8-1:0]   wstrb;
  logic                done;  // one-cycle completion pulse
  logic [xlen-1:0]     rdata;
  logic                err;   // bus returned an error

  // request side stays stable until done
  modport core (
    output req, we, addr, wdata, wstrb,
    input  done, rdata, err
  );

  modport master (
    input  req, we, addr, wdata, wstrb,
    output done, rdata, err
  );

endinterface

//--- src/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  // funct3 field
  localparam logic [2:0] f3_add  = 3'b000; // add, addi, sub
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;
  localparam logic [2:0] f3_word = 3'b010; // lw and sw
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;

  // funct7 field, register-register forms only
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem,
    st_halt
  } core_state_e;

  typedef enum logic [1:0] {
    trap_illegal    = 2'd0,
    trap_misaligned = 2'd1,
    trap_bus        = 2'd2
  } trap_code_e;

  // AXI response codes in use here
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

endpackage

//--- src/rv_top.sv
`timescale 1ns/1ps

module rv_top import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              awvalid,
  input  logic              awready,
  output logic [xlen-1:0]   awaddress,
  output logic [2:0]        awprot,
  output logic              wvalid,
  input  logic              wready,
  output logic [xlen-1:0]   wdata,
  output logic [xlen/8-1:0] wstrb,
  input  logic              bvalid,
  output logic              bready,
  input  logic [1:0]        bresp,
  output logic              arvalid,
  input  logic              arready,
  output logic [xlen-1:0]   araddress,
  output logic [2:0]        arprot,
  input  logic              rvalid,
  output logic              rready,
  input  logic [xlen-1:0]   rdata,
  input  logic [1:0]        rresp,
  output logic              trap,
  output trap_code_e        trap_code,
  output logic              retire_valid,
  output logic [xlen-1:0]   retire_pc,
  output logic [4:0]        retire_rd,
  output logic [xlen-1:0]   retire_rd_wdata
);

  rv_mem_if mem_bus ();

  rv_core #(.reset_pc(reset_pc)) i_core (
    .clk, .rst, .mem(mem_bus.core),
    .retire_valid, .retire_pc, .retire_rd, .retire_rd_wdata,
    .trap, .trap_code
  );

  rv_axil_master i_master (
    .clk, .rst, .mem(mem_bus.master),
    .awvalid, .awready, .awaddress, .awprot,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddress, .arprot,
    .rvalid, .rready, .rdata, .rresp
  );

endmodule
